/* hdl/ahb_mtx_pkg.sv */
// --------------------------------------------------------------------------
// Shared AHB bus matrix definitions for the output stage blocks
// Referenced by scoped name from every RTL file that needs them
// --------------------------------------------------------------------------

package ahb_mtx_pkg;

  // Port count limit and default bus widths
  localparam int MAX_PORTS = 8;             // Largest port count port_idx_t covers
  localparam int ADDR_W    = 32;            // Default HADDR width
  localparam int DATA_W    = 32;            // Default HWDATA width

  // --------------------------------------------------------------------------
  // Transfer encodings
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                         // No transfer
    BUSY   = 2'b01,                         // Burst pause
    NONSEQ = 2'b10,                         // First beat or single
    SEQ    = 2'b11                          // Burst continuation
  } htrans_e;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,                        // Single beat
    INCR   = 3'b001,                        // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // --------------------------------------------------------------------------
  // Plain control fields
  // --------------------------------------------------------------------------
  typedef logic [2:0] hsize_t;              // Transfer size
  typedef logic [3:0] hprot_t;              // Protection control
  typedef logic [3:0] hmaster_t;            // Master ID

  // Index of one bus-switch input
  typedef logic [$clog2(MAX_PORTS)-1:0] port_idx_t;

endpackage

/* hdl/ahb_output_arb.sv */
// --------------------------------------------------------------------------
// Round-robin arbiter for one slave output of the AHB bus matrix
// Holds the grant during bursts and locked sequences, registers the owner
// --------------------------------------------------------------------------

module ahb_output_arb #(
  parameter int P_NUM_PORTS = 5                       // Number of input ports
) (
  input  logic                   i_hclk,              // AHB clock
  input  logic                   HRESETn,             // Sync reset, active low
  input  logic [P_NUM_PORTS-1:0] i_req_op,            // Per-port requests
  input  logic                   i_hreadym,           // Address phase completes
  input  logic                   i_hselm,             // Owner select
  input  ahb_mtx_pkg::htrans_e   i_htransm,           // Owner transfer type
  input  logic                   i_hmastlockm,        // Owner lock
  output ahb_mtx_pkg::port_idx_t o_addr_in_port,      // Granted port
  output logic                   o_no_port            // No port granted
);

  logic                   hsel_lock;                  // Locked sequence seen while selected
  logic                   next_hsel_lock;
  logic                   hlock_arb;                  // Lock qualified by select history
  logic                   burst_hold;                 // Owner mid-burst
  logic                   hold_grant;                 // Keep current owner
  ahb_mtx_pkg::port_idx_t last_port;                  // Round-robin pointer
  ahb_mtx_pkg::port_idx_t rr_port;                    // Next owner candidate
  logic                   rr_found;                   // Any request present

  // --------------------------------------------------------------------------
  // Lock tracking
  // --------------------------------------------------------------------------
  // A locked master may address another slave in the middle of its locked
  // sequence, dropping HSEL here; hsel_lock keeps the sequence owned
  always_comb
  begin
    if (i_hselm && i_hmastlockm &&
        (i_htransm inside {ahb_mtx_pkg::NONSEQ, ahb_mtx_pkg::SEQ}))
    begin
      next_hsel_lock = 1'b1;                          // Active locked beat
    end
    else if (!i_hmastlockm)
    begin
      next_hsel_lock = 1'b0;                          // Sequence over
    end
    else
    begin
      next_hsel_lock = hsel_lock;
    end
  end

  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      hsel_lock <= 1'b0;
    end
    else if (i_hreadym)                               // Frozen under wait states
    begin
      hsel_lock <= next_hsel_lock;
    end
  end

  assign hlock_arb  = i_hmastlockm & (hsel_lock | i_hselm);
  assign burst_hold = (i_htransm == ahb_mtx_pkg::BUSY) ||
                      (i_htransm == ahb_mtx_pkg::SEQ);
  assign hold_grant = hlock_arb | burst_hold;

  // --------------------------------------------------------------------------
  // Round-robin search
  // --------------------------------------------------------------------------
  // Scan upward from the port after the last owner and wrap around
  always_comb
  begin
    ahb_mtx_pkg::port_idx_t cand;
    cand     = last_port;
    rr_found = 1'b0;
    rr_port  = last_port;
    for (int i = 1; i <= P_NUM_PORTS; i++)
    begin
      cand = ahb_mtx_pkg::port_idx_t'((int'(last_port) + i) % P_NUM_PORTS);
      if (!rr_found && i_req_op[cand])
      begin
        rr_found = 1'b1;                              // First hit wins
        rr_port  = cand;
      end
    end
  end

  // Grant register, one cycle after the request is sampled
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      o_addr_in_port <= '0;
      o_no_port      <= 1'b1;
      last_port      <= ahb_mtx_pkg::port_idx_t'(P_NUM_PORTS - 1); // Port 0 first
    end
    else if (i_hreadym && !hold_grant)
    begin
      o_no_port <= !rr_found;
      if (rr_found)
      begin
        o_addr_in_port <= rr_port;
        last_port      <= rr_port;
      end                                             // Index holds when idle
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  a_port_range: assert property (
    @(posedge i_hclk) disable iff (!HRESETn)
    int'(o_addr_in_port) < P_NUM_PORTS
  );

  // Wait states from the slave must not move the grant
  a_grant_frozen: assert property (
    @(posedge i_hclk) disable iff (!HRESETn)
    !i_hreadym |=> ($stable(o_addr_in_port) && $stable(o_no_port))
  );

endmodule

/* hdl/ahb_addr_mux.sv */
// --------------------------------------------------------------------------
// Address and control multiplexer for one slave output of the bus matrix
// Routes the granted port to the slave and decodes the one-hot active vector
// --------------------------------------------------------------------------

module ahb_addr_mux #(
  parameter int P_NUM_PORTS = 5,                          // Number of input ports
  parameter int P_ADDR_W    = ahb_mtx_pkg::ADDR_W         // Address width
) (
  input  ahb_mtx_pkg::port_idx_t                      i_addr_in_port, // Granted port
  input  logic                                        i_no_port,      // Nothing granted
  input  logic [P_NUM_PORTS-1:0]                      i_sel_op,
  input  logic [P_NUM_PORTS-1:0][P_ADDR_W-1:0]        i_addr_op,
  input  ahb_mtx_pkg::htrans_e  [P_NUM_PORTS-1:0]     i_trans_op,
  input  logic [P_NUM_PORTS-1:0]                      i_write_op,
  input  ahb_mtx_pkg::hsize_t   [P_NUM_PORTS-1:0]     i_size_op,
  input  ahb_mtx_pkg::hburst_e  [P_NUM_PORTS-1:0]     i_burst_op,
  input  ahb_mtx_pkg::hprot_t   [P_NUM_PORTS-1:0]     i_prot_op,
  input  ahb_mtx_pkg::hmaster_t [P_NUM_PORTS-1:0]     i_master_op,
  input  logic [P_NUM_PORTS-1:0]                      i_mastlock_op,
  output logic                                        o_hselm,        // Slave select
  output logic [P_ADDR_W-1:0]                         o_haddrm,       // Address
  output ahb_mtx_pkg::htrans_e                        o_htransm,      // Transfer type
  output logic                                        o_hwritem,      // Direction
  output ahb_mtx_pkg::hsize_t                         o_hsizem,       // Size
  output ahb_mtx_pkg::hburst_e                        o_hburstm,      // Burst type
  output ahb_mtx_pkg::hprot_t                         o_hprotm,       // Protection
  output ahb_mtx_pkg::hmaster_t                       o_hmasterm,     // Master ID
  output logic                                        o_hmastlockm,   // Locked transfer
  output logic [P_NUM_PORTS-1:0]                      o_active_op     // Owner one-hot
);

  // --------------------------------------------------------------------------
  // Address and control select
  // --------------------------------------------------------------------------
  always_comb
  begin
    o_hselm      = 1'b0;                              // Idle bus by default
    o_haddrm     = '0;
    o_htransm    = ahb_mtx_pkg::IDLE;
    o_hwritem    = 1'b0;
    o_hsizem     = '0;
    o_hburstm    = ahb_mtx_pkg::SINGLE;
    o_hprotm     = '0;
    o_hmasterm   = '0;
    o_hmastlockm = 1'b0;
    if (!i_no_port && (int'(i_addr_in_port) < P_NUM_PORTS))
    begin
      o_hselm      = i_sel_op[i_addr_in_port];
      o_haddrm     = i_addr_op[i_addr_in_port];
      o_htransm    = i_trans_op[i_addr_in_port];
      o_hwritem    = i_write_op[i_addr_in_port];
      o_hsizem     = i_size_op[i_addr_in_port];
      o_hburstm    = i_burst_op[i_addr_in_port];
      o_hprotm     = i_prot_op[i_addr_in_port];
      o_hmasterm   = i_master_op[i_addr_in_port];
      o_hmastlockm = i_mastlock_op[i_addr_in_port];
    end
  end

  // Active decode back to the input stages
  always_comb
  begin
    for (int p = 0; p < P_NUM_PORTS; p++)
    begin
      o_active_op[p] = !i_no_port && (i_addr_in_port == ahb_mtx_pkg::port_idx_t'(p));
    end
  end

  // At most one input stage may see its transfer as accepted here
  a_active_onehot: assert final ($onehot0(o_active_op));

endmodule

/* hdl/ahb_data_phase.sv */
// --------------------------------------------------------------------------
// Data phase of one slave output of the bus matrix
// Tracks the data-phase owner, muxes HWDATA and builds HREADYMUXM
// --------------------------------------------------------------------------

module ahb_data_phase #(
  parameter int P_NUM_PORTS = 5,                          // Number of input ports
  parameter int P_DATA_W    = ahb_mtx_pkg::DATA_W         // Data width
) (
  input  logic                                 i_hclk,          // AHB clock
  input  logic                                 HRESETn,         // Sync reset, active low
  input  ahb_mtx_pkg::port_idx_t               i_addr_in_port,  // Address phase owner
  input  logic                                 i_hselm,         // Address phase select
  input  logic                                 i_hreadyoutm,    // Slave ready
  input  logic [P_NUM_PORTS-1:0][P_DATA_W-1:0] i_wdata_op,      // Per-port write data
  output logic [P_DATA_W-1:0]                  o_hwdatam,       // Slave write data
  output logic                                 o_hreadymuxm     // Transfer done
);

  ahb_mtx_pkg::port_idx_t data_in_port;               // Data phase owner
  logic                   slave_sel;                  // Slave selected in data phase

  // --------------------------------------------------------------------------
  // Data phase registers
  // --------------------------------------------------------------------------
  // Both advance only when the address phase completes
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;
    end
    else if (o_hreadymuxm)
    begin
      data_in_port <= i_addr_in_port;
      slave_sel    <= i_hselm;
    end
  end

  // Write data from the previous address phase owner
  always_comb
  begin
    o_hwdatam = '0;
    if (int'(data_in_port) < P_NUM_PORTS)
    begin
      o_hwdatam = i_wdata_op[data_in_port];
    end
  end

  // --------------------------------------------------------------------------
  // HREADYMUXM generation
  // --------------------------------------------------------------------------
  // Slave response only counts when the slave owns the data phase
  assign o_hreadymuxm = slave_sel ? i_hreadyoutm : 1'b1;

  // A data phase that follows an unselected address phase is never stalled
  a_ready_unsel: assert property (
    @(posedge i_hclk) disable iff (!HRESETn)
    (o_hreadymuxm && !i_hselm) |=> o_hreadymuxm
  );

endmodule

/* hdl/ahb_output_stage.sv */
// --------------------------------------------------------------------------
// Output stage of a fully connected AHB bus matrix
// Arbitrates the bus-switch inputs onto one shared slave port
// --------------------------------------------------------------------------

module ahb_output_stage #(
  parameter int P_NUM_PORTS = 5,                          // Number of input ports
  parameter int P_ADDR_W    = ahb_mtx_pkg::ADDR_W,        // Address width
  parameter int P_DATA_W    = ahb_mtx_pkg::DATA_W         // Data width
) (
  input  logic                                    i_hclk,
  input  logic                                    HRESETn,
  // Bus-switch inputs
  input  logic [P_NUM_PORTS-1:0]                  i_sel_op,        // HSEL per port
  input  logic [P_NUM_PORTS-1:0][P_ADDR_W-1:0]    i_addr_op,       // HADDR per port
  input  ahb_mtx_pkg::htrans_e  [P_NUM_PORTS-1:0] i_trans_op,
  input  logic [P_NUM_PORTS-1:0]                  i_write_op,
  input  ahb_mtx_pkg::hsize_t   [P_NUM_PORTS-1:0] i_size_op,
  input  ahb_mtx_pkg::hburst_e  [P_NUM_PORTS-1:0] i_burst_op,
  input  ahb_mtx_pkg::hprot_t   [P_NUM_PORTS-1:0] i_prot_op,
  input  ahb_mtx_pkg::hmaster_t [P_NUM_PORTS-1:0] i_master_op,
  input  logic [P_NUM_PORTS-1:0]                  i_mastlock_op,
  input  logic [P_NUM_PORTS-1:0]                  i_held_tran_op,  // Held transfer pending
  input  logic [P_NUM_PORTS-1:0][P_DATA_W-1:0]    i_wdata_op,
  input  logic                                    i_hreadyoutm,    // Slave ready
  // Back to input stages
  output logic [P_NUM_PORTS-1:0]                  o_active_op,
  // Shared slave port
  output logic                                    o_hselm,
  output logic [P_ADDR_W-1:0]                     o_haddrm,
  output ahb_mtx_pkg::htrans_e                    o_htransm,
  output logic                                    o_hwritem,
  output ahb_mtx_pkg::hsize_t                     o_hsizem,
  output ahb_mtx_pkg::hburst_e                    o_hburstm,
  output ahb_mtx_pkg::hprot_t                     o_hprotm,
  output ahb_mtx_pkg::hmaster_t                   o_hmasterm,
  output logic                                    o_hmastlockm,
  output logic [P_DATA_W-1:0]                     o_hwdatam,
  output logic                                    o_hreadymuxm
);

  logic [P_NUM_PORTS-1:0] req_op;                     // Per-port requests
  ahb_mtx_pkg::port_idx_t addr_in_port;               // Address phase owner
  logic                   no_port;                    // No owner

  // Port index type limits the matrix width
  if (P_NUM_PORTS > ahb_mtx_pkg::MAX_PORTS)
  begin : g_port_limit
    $error("P_NUM_PORTS exceeds MAX_PORTS");
  end

  assign req_op = i_held_tran_op & i_sel_op;          // Held transfer aimed here

  // --------------------------------------------------------------------------
  // Submodules
  // --------------------------------------------------------------------------
  ahb_output_arb #(
    .P_NUM_PORTS (P_NUM_PORTS)
  ) u_output_arb (
    .i_hclk         (i_hclk),
    .HRESETn        (HRESETn),
    .i_req_op       (req_op),
    .i_hreadym      (o_hreadymuxm),
    .i_hselm        (o_hselm),
    .i_htransm      (o_htransm),
    .i_hmastlockm   (o_hmastlockm),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  ahb_addr_mux #(
    .P_NUM_PORTS (P_NUM_PORTS),
    .P_ADDR_W    (P_ADDR_W)
  ) u_addr_mux (
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .i_sel_op       (i_sel_op),
    .i_addr_op      (i_addr_op),
    .i_trans_op     (i_trans_op),
    .i_write_op     (i_write_op),
    .i_size_op      (i_size_op),
    .i_burst_op     (i_burst_op),
    .i_prot_op      (i_prot_op),
    .i_master_op    (i_master_op),
    .i_mastlock_op  (i_mastlock_op),
    .o_hselm        (o_hselm),
    .o_haddrm       (o_haddrm),
    .o_htransm      (o_htransm),
    .o_hwritem      (o_hwritem),
    .o_hsizem       (o_hsizem),
    .o_hburstm      (o_hburstm),
    .o_hprotm       (o_hprotm),
    .o_hmasterm     (o_hmasterm),
    .o_hmastlockm   (o_hmastlockm),
    .o_active_op    (o_active_op)
  );

  ahb_data_phase #(
    .P_NUM_PORTS (P_NUM_PORTS),
    .P_DATA_W    (P_DATA_W)
  ) u_data_phase (
    .i_hclk         (i_hclk),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_hselm        (o_hselm),
    .i_hreadyoutm   (i_hreadyoutm),
    .i_wdata_op     (i_wdata_op),
    .o_hwdatam      (o_hwdatam),
    .o_hreadymuxm   (o_hreadymuxm)
  );

endmodule

/* verif/tb_ahb_output_stage.sv */
// --------------------------------------------------------------------------
// Self-checking testbench for the AHB bus matrix output stage
// Replays the stimulus file one step per clock and checks the slave port
// --------------------------------------------------------------------------

module tb_ahb_output_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    NUM_PORTS     = 5;
  localparam int    ADDR_W        = ahb_mtx_pkg::ADDR_W;
  localparam int    DATA_W        = ahb_mtx_pkg::DATA_W;
  localparam int    MAX_STEPS     = 200;                // Bound on file length
  localparam int    RESET_TIMEOUT = 20;                 // Cycles to reach idle
  localparam string STIM_FILE     = "verif/ahb_output_stimulus.txt";

  logic                                   hclk;
  logic                                   hresetn;
  logic [NUM_PORTS-1:0]                   sel_op;
  logic [NUM_PORTS-1:0][ADDR_W-1:0]       addr_op;
  ahb_mtx_pkg::htrans_e  [NUM_PORTS-1:0]  trans_op;
  logic [NUM_PORTS-1:0]                   write_op;
  ahb_mtx_pkg::hsize_t   [NUM_PORTS-1:0]  size_op;
  ahb_mtx_pkg::hburst_e  [NUM_PORTS-1:0]  burst_op;
  ahb_mtx_pkg::hprot_t   [NUM_PORTS-1:0]  prot_op;
  ahb_mtx_pkg::hmaster_t [NUM_PORTS-1:0]  master_op;
  logic [NUM_PORTS-1:0]                   mastlock_op;
  logic [NUM_PORTS-1:0]                   held_tran_op;
  logic [NUM_PORTS-1:0][DATA_W-1:0]       wdata_op;
  logic                                   hreadyoutm;
  logic [NUM_PORTS-1:0]                   active_op;
  logic                                   hselm;
  logic [ADDR_W-1:0]                      haddrm;
  ahb_mtx_pkg::htrans_e                   htransm;
  logic                                   hwritem;
  ahb_mtx_pkg::hsize_t                    hsizem;
  ahb_mtx_pkg::hburst_e                   hburstm;
  ahb_mtx_pkg::hprot_t                    hprotm;
  ahb_mtx_pkg::hmaster_t                  hmasterm;
  logic                                   hmastlockm;
  logic [DATA_W-1:0]                      hwdatam;
  logic                                   hreadymuxm;

  always #50 hclk = ~hclk;                              // 100 ns period

  ahb_output_stage #(
    .P_NUM_PORTS (NUM_PORTS),
    .P_ADDR_W    (ADDR_W),
    .P_DATA_W    (DATA_W)
  ) i_dut (
    .i_hclk (hclk), .HRESETn (hresetn),
    .i_sel_op (sel_op), .i_addr_op (addr_op), .i_trans_op (trans_op),
    .i_write_op (write_op), .i_size_op (size_op), .i_burst_op (burst_op),
    .i_prot_op (prot_op), .i_master_op (master_op), .i_mastlock_op (mastlock_op),
    .i_held_tran_op (held_tran_op), .i_wdata_op (wdata_op), .i_hreadyoutm (hreadyoutm),
    .o_active_op (active_op), .o_hselm (hselm), .o_haddrm (haddrm),
    .o_htransm (htransm), .o_hwritem (hwritem), .o_hsizem (hsizem),
    .o_hburstm (hburstm), .o_hprotm (hprotm), .o_hmasterm (hmasterm),
    .o_hmastlockm (hmastlockm), .o_hwdatam (hwdatam), .o_hreadymuxm (hreadymuxm)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [ADDR_W-1:0] selected_addr(input int p);
    return ADDR_W'(32'h8000_0000 + (p << 8));           // Fixed address per port
  endfunction

  function automatic ahb_mtx_pkg::htrans_e trans_from_letter(input byte c);
    case (c)
      "B":     return ahb_mtx_pkg::BUSY;
      "N":     return ahb_mtx_pkg::NONSEQ;
      "S":     return ahb_mtx_pkg::SEQ;
      default: return ahb_mtx_pkg::IDLE;
    endcase
  endfunction

  function automatic bit trans_code_ok(input string s, input int len);
    bit ok;
    ok = (s.len() == len);
    for (int i = 0; i < s.len(); i++)
    begin
      ok = ok && (s[i] inside {"I", "B", "N", "S"});
    end
    return ok;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_port(input string test, input logic [NUM_PORTS-1:0] exp,
                            input logic [NUM_PORTS-1:0] act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s active: expected %b actual %b", test, exp, act));
    end
  endtask

  task automatic check_trans(input string test, input ahb_mtx_pkg::htrans_e exp,
                             input ahb_mtx_pkg::htrans_e act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s htrans: expected %s actual %s",
                         test, exp.name(), act.name()));
    end
  endtask

  task automatic check_word(input string test, input string field,
                            input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s %s: expected %h actual %h", test, field, exp, act));
    end
  endtask

  task automatic check_bit(input string test, input string field,
                           input logic exp, input logic act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s %s: expected %b actual %b", test, field, exp, act));
    end
  endtask

  task automatic check_size(input string test, input ahb_mtx_pkg::hsize_t exp,
                            input ahb_mtx_pkg::hsize_t act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s hsize: expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic check_burst(input string test, input ahb_mtx_pkg::hburst_e exp,
                             input ahb_mtx_pkg::hburst_e act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s hburst: expected %s actual %s",
                         test, exp.name(), act.name()));
    end
  endtask

  task automatic check_prot(input string test, input ahb_mtx_pkg::hprot_t exp,
                            input ahb_mtx_pkg::hprot_t act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s hprot: expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic check_master(input string test, input ahb_mtx_pkg::hmaster_t exp,
                              input ahb_mtx_pkg::hmaster_t act);
    if (act !== exp)
    begin
      fail_run($sformatf("MISMATCH %s hmaster: expected %h actual %h", test, exp, act));
    end
  endtask

  // Control fields follow the owner named by the expected active vector
  task automatic check_controls(input string test, input logic [NUM_PORTS-1:0] exp_act);
    logic                  exp_write;
    logic                  exp_lock;
    ahb_mtx_pkg::hsize_t   exp_size;
    ahb_mtx_pkg::hburst_e  exp_burst;
    ahb_mtx_pkg::hprot_t   exp_prot;
    ahb_mtx_pkg::hmaster_t exp_master;
    exp_write  = 1'b0;                                  // Zeroed bus with no owner
    exp_lock   = 1'b0;
    exp_size   = '0;
    exp_burst  = ahb_mtx_pkg::SINGLE;
    exp_prot   = '0;
    exp_master = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (exp_act[p])
      begin
        exp_write  = write_op[p];
        exp_lock   = mastlock_op[p];
        exp_size   = size_op[p];
        exp_burst  = burst_op[p];
        exp_prot   = prot_op[p];
        exp_master = master_op[p];
      end
    end
    check_bit(test, "hwritem", exp_write, hwritem);
    check_bit(test, "hmastlockm", exp_lock, hmastlockm);
    check_size(test, exp_size, hsizem);
    check_burst(test, exp_burst, hburstm);
    check_prot(test, exp_prot, hprotm);
    check_master(test, exp_master, hmasterm);
  endtask

  // Unselected ports carry random addresses the slave must never see
  task automatic drive_step(input logic [NUM_PORTS-1:0] sel, input logic [NUM_PORTS-1:0] held,
                            input logic [NUM_PORTS-1:0] lock, input string trans_str,
                            input logic rdy, input logic [DATA_W-1:0] wd [NUM_PORTS]);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      sel_op[p]       = sel[p];
      held_tran_op[p] = held[p];
      mastlock_op[p]  = lock[p];
      trans_op[p]     = trans_from_letter(trans_str[NUM_PORTS-1-p]); // Port 4 leftmost
      wdata_op[p]     = wd[p];
      addr_op[p]      = sel[p] ? selected_addr(p) : ADDR_W'($urandom);
    end
    hreadyoutm = rdy;
  endtask

  task automatic wait_reset_idle();
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < RESET_TIMEOUT))
    begin
      @(posedge hclk);
      #10;
      cycles++;
      seen = (hreadymuxm === 1'b1) && (active_op === '0) && (htransm === ahb_mtx_pkg::IDLE);
    end
    if (!seen)
    begin
      fail_run("Timeout: the DUT did not reach an idle slave port after reset");
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int                   fd;
    int                   code;
    int                   steps;
    bit                   done;
    string                name, trans_str, exp_trans_str, exp_addr_str, rest;
    logic [NUM_PORTS-1:0] sel, held, lock, exp_active;
    logic                 rdy, exp_hsel, exp_rdm;
    logic [DATA_W-1:0]    wd [NUM_PORTS];
    logic [DATA_W-1:0]    exp_hwdata;
    logic [ADDR_W-1:0]    exp_addr;
    void'($urandom(7250));                              // Single seed for the run
    hclk       = 1'b0;
    hresetn    = 1'b0;
    hreadyoutm = 1'b1;
    // Control fields differ per port so a wrong select shows up
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      sel_op[p]       = 1'b0;
      held_tran_op[p] = 1'b0;
      mastlock_op[p]  = 1'b0;
      trans_op[p]     = ahb_mtx_pkg::IDLE;
      write_op[p]     = p[0];                           // Reads and writes alternate
      size_op[p]      = ahb_mtx_pkg::hsize_t'(p % 3);   // Byte, half and word
      burst_op[p]     = ahb_mtx_pkg::hburst_e'(p + 1);
      prot_op[p]      = ahb_mtx_pkg::hprot_t'(p + 8);
      master_op[p]    = ahb_mtx_pkg::hmaster_t'(p);
      addr_op[p]      = ADDR_W'($urandom);
      wdata_op[p]     = '0;
    end
    repeat (4) @(posedge hclk);
    #10;
    hresetn = 1'b1;
    wait_reset_idle();
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      fail_run("Could not open the stimulus file");
    end
    steps = 0;
    done  = 1'b0;
    while (!done)
    begin
      code = $fscanf(fd, "%s", name);
      if (code != 1)
      begin
        done = 1'b1;                                    // End of file
      end
      else if (name[0] == "#")
      begin
        code = $fgets(rest, fd);                        // Skip comment line
      end
      else
      begin
        if (steps >= MAX_STEPS)
        begin
          fail_run("The stimulus file holds more steps than the run allows");
        end
        code = $fscanf(fd, "%b %b %s %b %b %h %h %h %h %h %b %b %s %s %h %b",
                       sel, held, trans_str, lock, rdy, wd[0], wd[1], wd[2], wd[3], wd[4],
                       exp_active, exp_hsel, exp_trans_str, exp_addr_str, exp_hwdata, exp_rdm);
        if ((code != 16) || !trans_code_ok(trans_str, NUM_PORTS) ||
            !trans_code_ok(exp_trans_str, 1))
        begin
          fail_run($sformatf("Stimulus line for step %s could not be read", name));
        end
        drive_step(sel, held, lock, trans_str, rdy, wd); // 10 ns after the edge
        #80;                                            // Just before the next edge
        check_port(name, exp_active, active_op);
        check_bit(name, "hselm", exp_hsel, hselm);
        check_trans(name, trans_from_letter(exp_trans_str[0]), htransm);
        check_controls(name, exp_active);
        if (exp_addr_str != "-")
        begin
          code = $sscanf(exp_addr_str, "%h", exp_addr);
          check_word(name, "haddrm", exp_addr, haddrm);
        end
        check_word(name, "hwdatam", exp_hwdata, hwdatam);
        check_bit(name, "hreadymuxm", exp_rdm, hreadymuxm);
        steps++;
        @(posedge hclk);
        #10;
      end
    end
    $fclose(fd);
    if (steps > 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      fail_run("The stimulus file held no steps");
    end
  end

endmodule

/* compile.f */
hdl/ahb_mtx_pkg.sv
hdl/ahb_output_arb.sv
hdl/ahb_addr_mux.sv
hdl/ahb_data_phase.sv
hdl/ahb_output_stage.sv
verif/tb_ahb_output_stage.sv

/* verif/ahb_output_stimulus.txt */
# name sel held trans lock hreadyout wd0 wd1 wd2 wd3 wd4 then expected active hsel htrans haddr hwdata hreadymux
# Bit vectors and trans letters (I B N S) run port 4 down to 0, words are hex, haddr - is not checked
reset_idle       00000 00000 IIIII 00000 1 10  11  12  13  14   00000 0 I 00000000 10  1
reset_idle       00000 00000 IIIII 00000 1 20  21  22  23  24   00000 0 I 00000000 20  1
rr_all_req       11111 11111 NNNNN 00000 1 30  31  32  33  34   00000 0 I 00000000 30  1
rr_own_p0        11111 11111 NNNNN 00000 1 40  41  42  43  44   00001 1 N 80000000 40  1
rr_own_p1        11111 11111 NNNNN 00000 1 50  51  52  53  54   00010 1 N 80000100 50  1
rr_own_p2        11111 11111 NNNNN 00000 1 60  61  62  63  64   00100 1 N 80000200 61  1
rr_own_p3        11111 11111 NNNNN 00000 1 70  71  72  73  74   01000 1 N 80000300 72  1
rr_own_p4        11111 11111 NNNNN 00000 1 80  81  82  83  84   10000 1 N 80000400 83  1
rr_own_p0_again  11111 11111 NNNNN 00000 1 90  91  92  93  94   00001 1 N 80000000 94  1
rr_drain         00000 00000 IIIII 00000 1 a0  a1  a2  a3  a4   00010 0 I - a0  1
single_p2_req    00100 00100 IINII 00000 1 b0  b1  b2  b3  b4   00000 0 I 00000000 b1  1
single_p2_addr   00100 00100 IINII 00000 1 c0  c1  c2  c3  c4   00100 1 N 80000200 c1  1
single_p2_data   00000 00000 IIIII 00000 1 d0  d1  d2  d3  d4   00100 0 I - d2  1
burst_p1_req     00010 00010 IIINI 00000 1 e0  e1  e2  e3  e4   00000 0 I 00000000 e2  1
burst_p1_nseq    00010 00010 IIINI 00000 1 f0  f1  f2  f3  f4   00010 1 N 80000100 f2  1
burst_p1_seq     01010 01010 INISI 00000 1 100 101 102 103 104  00010 1 S 80000100 101 1
burst_p1_seq     01010 01010 INISI 00000 1 110 111 112 113 114  00010 1 S 80000100 111 1
burst_p1_busy    01010 01010 INIBI 00000 1 120 121 122 123 124  00010 1 B 80000100 121 1
burst_p1_seq     01010 01010 INISI 00000 1 130 131 132 133 134  00010 1 S 80000100 131 1
burst_p1_end     01000 01000 INIII 00000 1 140 141 142 143 144  00010 0 I - 141 1
burst_p3_own     01000 01000 INIII 00000 1 150 151 152 153 154  01000 1 N 80000300 151 1
burst_p3_data    00000 00000 IIIII 00000 1 160 161 162 163 164  01000 0 I - 163 1
lock_p4_req      10000 10000 NIIII 10000 1 170 171 172 173 174  00000 0 I 00000000 173 1
lock_p4_nseq     10001 10001 NIIIN 10000 1 180 181 182 183 184  10000 1 N 80000400 183 1
lock_p4_desel    00001 00001 NIIIN 10000 1 190 191 192 193 194  10000 0 N - 194 1
lock_p4_desel    00001 00001 IIIIN 10000 1 1a0 1a1 1a2 1a3 1a4  10000 0 I - 1a4 1
lock_p4_resel    10001 10001 NIIIN 10000 1 1b0 1b1 1b2 1b3 1b4  10000 1 N 80000400 1b4 1
lock_p4_unlock   00001 00001 IIIIN 00000 1 1c0 1c1 1c2 1c3 1c4  10000 0 I - 1c4 1
lock_p0_own      00001 00001 IIIIN 00000 1 1d0 1d1 1d2 1d3 1d4  00001 1 N 80000000 1d4 1
wait_p0          00101 00101 IININ 00000 0 1e0 1e1 1e2 1e3 1e4  00001 1 N 80000000 1e0 0
wait_p0_hold     00101 00101 IININ 00000 0 1f0 1f1 1f2 1f3 1f4  00001 1 N 80000000 1f0 0
wait_p0_release  00101 00101 IININ 00000 1 200 201 202 203 204  00001 1 N 80000000 200 1
wait_after_p2    00100 00100 IINII 00000 1 210 211 212 213 214  00100 1 N 80000200 210 1
final_data       00000 00000 IIIII 00000 1 220 221 222 223 224  00100 0 I - 222 1
final_idle       00000 00000 IIIII 00000 1 230 231 232 233 234  00000 0 I 00000000 232 1
